/* list.f */
logic/sdram_geom_pkg.sv
logic/sdram_cmd_pkg.sv
logic/sdram_bank_track.sv
logic/sdram_req_latch.sv
logic/sdram_cmd_sched.sv
logic/sdram_front_top.sv
verification/sdram_front_assert.sv
verification/sdram_front_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the front-end testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module sdram_front_tb -o sim_front
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_front > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0

/* verification/sdram_front_tb.sv */
`default_nettype none

// Testbench for the SDRAM request front end.
// An open-row model, fed from the observed command bus, predicts the
// command that each pending request must get next.
module sdram_front_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int COL_W = 9;
    localparam int AW = sdram_geom_pkg::ROW_W + COL_W;
    localparam int REF_PERIOD = 64;
    localparam int TIMEOUT = 400;
    localparam int N_ROUNDS = 6;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [3:0][AW-1:0] bank_addr = '0;
    sdram_geom_pkg::bank_mask_t rd = '0;
    sdram_geom_pkg::bank_mask_t wr = '0;
    logic prog_en = 1'b0;
    logic prog_rd = 1'b0;
    logic prog_wr = 1'b0;
    logic [AW+1:0] prog_addr = '0;
    sdram_cmd_pkg::sdram_cmd_t cmd;
    sdram_geom_pkg::bank_mask_t ack;
    logic prog_ack;

    // Shadow inputs, copied onto the DUT at each falling edge.
    logic [3:0][AW-1:0] s_addr = '0;
    sdram_geom_pkg::bank_mask_t s_rd = '0;
    sdram_geom_pkg::bank_mask_t s_wr = '0;
    logic s_pen = 1'b0;
    logic s_prd = 1'b0;
    logic s_pwr = 1'b0;
    logic [AW+1:0] s_paddr = '0;

    // Open-row model and bookkeeping.
    sdram_geom_pkg::bank_mask_t m_open = '0;
    sdram_geom_pkg::row_t m_row [4];
    // Set while the last command on the bus was a PREA.
    logic m_prea = 1'b0;
    // Any request on the inputs in the previous cycle, as the latch saw it.
    logic prev_req = 1'b0;
    int n_cmd [4];
    int n_ack [4];
    logic saw_ref;
    logic timed_out = 1'b0;
    int err_cnt = 0;
    int chk_cnt = 0;
    int tests = 0;
    int tests_bad = 0;
    int err_at;

    sdram_front_top #(.LATCH(1), .COL_W(COL_W), .REF_PERIOD(REF_PERIOD)) u_sdram_front_top (
        .clk(clk), .rst(rst), .bank_addr(bank_addr), .rd(rd), .wr(wr),
        .prog_en(prog_en), .prog_rd(prog_rd), .prog_wr(prog_wr), .prog_addr(prog_addr),
        .cmd(cmd), .ack(ack), .prog_ack(prog_ack)
    );

    always #2 clk = ~clk;

    task automatic report_fail(input string msg);
        err_cnt++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic check_cmd(input sdram_cmd_pkg::sdram_cmd_t got,
                             input sdram_cmd_pkg::sdram_op_e op, input sdram_geom_pkg::bank_t bank,
                             input sdram_geom_pkg::row_t row, input sdram_geom_pkg::col_t col);
        chk_cnt++;
        if (got.op !== op || got.bank !== bank || got.row !== row || got.col !== col) begin
            report_fail($sformatf("cmd %s b%0d r%h c%h, expected %s b%0d r%h c%h",
                got.op.name(), got.bank, got.row, got.col, op.name(), bank, row, col));
        end
    endtask

    task automatic check_mask(input sdram_geom_pkg::bank_mask_t got,
                              input sdram_geom_pkg::bank_mask_t exp, input string what);
        chk_cnt++;
        if (got !== exp) report_fail($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        chk_cnt++;
        if (got !== exp) report_fail($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_row(input sdram_geom_pkg::row_t got, input sdram_geom_pkg::row_t exp);
        chk_cnt++;
        if (got !== exp) report_fail($sformatf("model row %h, expected %h", got, exp));
    endtask

    // The run stops after the current test and ends in failure.
    task automatic note_timeout(input string what);
        timed_out = 1'b1;
        $display("Timed out waiting for %s", what);
    endtask

    // Closed bank needs ACT, another open row needs PRE, a hit gets the access.
    function automatic sdram_cmd_pkg::sdram_op_e next_op(input sdram_geom_pkg::bank_t b,
            input sdram_geom_pkg::row_t row, input logic is_rd);
        if (m_open[b] && m_row[b] == row) return is_rd ? sdram_cmd_pkg::RD : sdram_cmd_pkg::WR;
        if (m_open[b]) return sdram_cmd_pkg::PRE;
        return sdram_cmd_pkg::ACT;
    endfunction

    // Checks the command of this cycle, then updates the model and the requesters.
    task automatic observe();
        sdram_cmd_pkg::sdram_op_e op;
        sdram_geom_pkg::bank_mask_t exp_ack;
        sdram_geom_pkg::bank_t b;
        logic [AW-1:0] a;
        logic r;
        logic exp_pack;
        exp_ack = '0;
        exp_pack = 1'b0;
        b = cmd.bank;
        if (cmd.op inside {sdram_cmd_pkg::ACT, sdram_cmd_pkg::PRE,
                           sdram_cmd_pkg::RD, sdram_cmd_pkg::WR}) begin
            if (prog_en) begin
                b = prog_addr[AW+1 -: 2];
                a = prog_addr[AW-1:0];
                r = prog_rd;
            end else begin
                if (!(rd[b] | wr[b])) begin
                    err_cnt++;
                    $display("Command sent to bank %0d with no request pending at %0t", b, $time);
                end
                a = bank_addr[b];
                r = rd[b];
                n_cmd[b]++;
            end
            op = next_op(b, a[AW-1 -: sdram_geom_pkg::ROW_W], r);
            check_cmd(cmd, op, b, a[AW-1 -: sdram_geom_pkg::ROW_W],
                      sdram_geom_pkg::col_t'(a[COL_W-1:0]));
            if (op inside {sdram_cmd_pkg::RD, sdram_cmd_pkg::WR}) begin
                if (prog_en) exp_pack = 1'b1;
                else exp_ack[b] = 1'b1;
            end
        end
        check_mask(ack, exp_ack, "ack");
        check_flag(prog_ack, exp_pack, "prog_ack");
        case (cmd.op)
            sdram_cmd_pkg::ACT: begin
                m_open[cmd.bank] = 1'b1;
                m_row[cmd.bank] = cmd.row;
            end
            sdram_cmd_pkg::PRE: m_open[cmd.bank] = 1'b0;
            sdram_cmd_pkg::PREA: begin
                // The latch is one cycle behind, so last cycle's inputs decide.
                check_flag(prev_req, 1'b0, "request pending ahead of PREA");
                m_open = '0;
            end
            sdram_cmd_pkg::REF: begin
                check_flag(m_prea, 1'b1, "PREA ahead of REF");
                m_open = '0;
                saw_ref = 1'b1;
            end
            default: ;
        endcase
        if (cmd.op != sdram_cmd_pkg::NOP) m_prea = (cmd.op == sdram_cmd_pkg::PREA);
        prev_req = |rd || |wr || (prog_en && (prog_rd || prog_wr));
        // Requesters drop their request in the cycle after the ack.
        for (int i = 0; i < 4; i++) begin
            if (ack[i]) begin
                s_rd[i] = 1'b0;
                s_wr[i] = 1'b0;
                n_ack[i]++;
            end
        end
        if (prog_ack) begin
            s_prd = 1'b0;
            s_pwr = 1'b0;
        end
    endtask

    // Drives on the falling edge and samples just after, where cmd is settled.
    task automatic tick();
        @(negedge clk);
        bank_addr = s_addr;
        rd = s_rd;
        wr = s_wr;
        prog_en = s_pen;
        prog_rd = s_prd;
        prog_wr = s_pwr;
        prog_addr = s_paddr;
        #1;
        observe();
    endtask

    task automatic raise(input int b, input sdram_geom_pkg::row_t row, input logic is_rd);
        s_addr[b] = {row, COL_W'($urandom)};
        s_rd[b] = is_rd;
        s_wr[b] = !is_rd;
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while ((|s_rd || |s_wr || s_prd || s_pwr) && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (|s_rd || |s_wr || s_prd || s_pwr) note_timeout(what);
    endtask

    task automatic start_test();
        for (int i = 0; i < 4; i++) begin
            n_cmd[i] = 0;
            n_ack[i] = 0;
        end
        saw_ref = 1'b0;
        err_at = err_cnt;
    endtask

    // exp_n is the bank's command count when no refresh cut in, -1 to skip.
    task automatic end_test(input string name, input int b, input int exp_n);
        if (exp_n >= 0 && !saw_ref && n_cmd[b] != exp_n) begin
            report_fail($sformatf("%s took %0d commands, expected %0d", name, n_cmd[b], exp_n));
        end
        tests++;
        if (err_cnt != err_at) tests_bad++;
        $display("test %s: %0d errors", name, err_cnt - err_at);
    endtask

    // Runs the behaviors in order and returns at the first timeout.
    task automatic run_tests();
        int b;
        int n;
        int left [4];
        logic busy;
        sdram_geom_pkg::row_t row;

        b = $urandom_range(0, 3);
        row = sdram_geom_pkg::row_t'($urandom);
        start_test();
        raise(b, row, 1'($urandom));
        wait_idle("closed bank ack");
        if (timed_out) return;
        end_test("closed_bank", b, 2);

        start_test();
        raise(b, row, 1'($urandom));
        wait_idle("row hit ack");
        if (timed_out) return;
        end_test("row_hit", b, 1);

        start_test();
        raise(b, row ^ 12'h5a1, 1'($urandom));
        wait_idle("row miss ack");
        if (timed_out) return;
        check_row(m_row[b], row ^ 12'h5a1);
        end_test("row_miss", b, 3);

        // A small row set mixes hits and misses across the banks.
        start_test();
        for (int i = 0; i < 4; i++) left[i] = N_ROUNDS;
        busy = 1'b1;
        n = 0;
        while (busy && n < TIMEOUT * N_ROUNDS) begin
            busy = 1'b0;
            for (int i = 0; i < 4; i++) begin
                if (left[i] > 0 && !(rd[i] | wr[i]) && !(s_rd[i] | s_wr[i])) begin
                    raise(i, sdram_geom_pkg::row_t'($urandom_range(0, 2)), 1'($urandom));
                    left[i]--;
                end
                if (left[i] > 0 || s_rd[i] || s_wr[i]) busy = 1'b1;
            end
            tick();
            n++;
        end
        if (busy) begin
            note_timeout("concurrent requests");
            return;
        end
        for (int i = 0; i < 4; i++) begin
            if (n_ack[i] != N_ROUNDS) begin
                report_fail($sformatf("bank %0d acked %0d times", i, n_ack[i]));
            end
        end
        end_test("concurrency", 0, -1);

        // Bank requests wait behind the programming port.
        start_test();
        raise(0, sdram_geom_pkg::row_t'($urandom), 1'($urandom));
        raise(2, sdram_geom_pkg::row_t'($urandom), 1'($urandom));
        s_pen = 1'b1;
        s_paddr = (AW + 2)'($urandom);
        s_prd = 1'($urandom);
        s_pwr = !s_prd;
        n = 0;
        while ((s_prd || s_pwr) && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (s_prd || s_pwr) begin
            note_timeout("prog_ack");
            return;
        end
        s_pen = 1'b0;
        wait_idle("bank acks after programming");
        if (timed_out) return;
        if (n_ack[0] != 1 || n_ack[2] != 1) report_fail("held bank requests not acked once");
        end_test("prog_takeover", 0, -1);

        start_test();
        n = 0;
        while (!saw_ref && n < 2 * REF_PERIOD + 20) begin
            tick();
            n++;
        end
        if (!saw_ref) begin
            note_timeout("idle refresh");
            return;
        end
        // The access after the refresh must start from a closed bank.
        saw_ref = 1'b0;
        b = $urandom_range(0, 3);
        raise(b, sdram_geom_pkg::row_t'($urandom), 1'($urandom));
        wait_idle("ack after refresh");
        if (timed_out) return;
        end_test("idle_refresh", b, 2);
    endtask

    initial begin
        void'($urandom(32'h511c));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_tests();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests_bad, chk_cnt, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/sdram_front_assert.sv */
`default_nettype none

// Protocol properties of the command scheduler, bound into every instance.
module sdram_front_assert (
    input wire logic                       clk,
    input wire logic                       rst,
    input wire sdram_cmd_pkg::sdram_cmd_t  cmd,
    input wire sdram_geom_pkg::bank_mask_t ack
);
    timeunit 1ns;
    timeprecision 1ps;

    // Each command stands in for device timing with one idle cycle after it.
    a_gap: assert property (@(posedge clk) disable iff (rst)
        cmd.op != sdram_cmd_pkg::NOP |=> cmd.op == sdram_cmd_pkg::NOP)
        else $error("command not followed by a NOP");

    // At most one bank is acknowledged per cycle.
    a_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ack))
        else $error("more than one ack bit set");

    // An ack travels with the RD or WR of its own bank.
    a_ack_cmd: assert property (@(posedge clk) disable iff (rst)
        |ack |-> (cmd.op inside {sdram_cmd_pkg::RD, sdram_cmd_pkg::WR}) && ack[cmd.bank])
        else $error("ack without a matching RD or WR");

    // REFRESH needs every bank closed, so PREA goes two cycles ahead.
    a_ref: assert property (@(posedge clk) disable iff (rst)
        cmd.op == sdram_cmd_pkg::REF |-> $past(cmd.op, 2) == sdram_cmd_pkg::PREA)
        else $error("REF without PREA two cycles before");

endmodule

bind sdram_cmd_sched sdram_front_assert u_sdram_front_assert (
    .clk (clk),
    .rst (rst),
    .cmd (cmd),
    .ack (ack)
);

`default_nettype wire

/* logic/sdram_front_top.sv */
`default_nettype none

// Request front end of a four-bank SDRAM controller.
// Four open-row trackers watch the command bus, the latch matches the
// requests against them, and the scheduler drives the bus.
module sdram_front_top #(
    parameter int   LATCH      = 0,
    parameter int   COL_W      = 9,
    parameter int   REF_PERIOD = 64,
    localparam int  AW         = sdram_geom_pkg::ROW_W + COL_W
) (
    input  wire logic                                      clk,
    input  wire logic                                      rst,
    input  wire logic [sdram_geom_pkg::BANK_N-1:0][AW-1:0] bank_addr,
    input  wire sdram_geom_pkg::bank_mask_t                rd,
    input  wire sdram_geom_pkg::bank_mask_t                wr,
    input  wire logic                                      prog_en,
    input  wire logic                                      prog_rd,
    input  wire logic                                      prog_wr,
    input  wire logic [AW+1:0]                             prog_addr,
    output sdram_cmd_pkg::sdram_cmd_t                      cmd,
    output sdram_geom_pkg::bank_mask_t                     ack,
    output logic                                           prog_ack
);

    sdram_geom_pkg::row_t [sdram_geom_pkg::BANK_N-1:0] open_row;
    sdram_geom_pkg::bank_mask_t                        open;
    logic [sdram_geom_pkg::BANK_N-1:0][AW-1:0]         addr_l;
    sdram_geom_pkg::bank_mask_t                        rd_l;
    sdram_geom_pkg::bank_mask_t                        wr_l;
    sdram_geom_pkg::bank_mask_t                        match;
    logic                                              noreq;

    // One tracker per bank, told its own index.
    for (genvar i = 0; i < sdram_geom_pkg::BANK_N; i++) begin : g_track
        sdram_bank_track u_sdram_bank_track (
            .clk      (clk),
            .rst      (rst),
            .bank_id  (sdram_geom_pkg::bank_t'(i)),
            .cmd      (cmd),
            .open_row (open_row[i]),
            .open     (open[i])
        );
    end

    sdram_req_latch #(
        .LATCH (LATCH),
        .COL_W (COL_W)
    ) u_sdram_req_latch (
        .clk       (clk),
        .rst       (rst),
        .bank_addr (bank_addr),
        .open_row  (open_row),
        .open      (open),
        .rd        (rd),
        .wr        (wr),
        .prog_en   (prog_en),
        .prog_rd   (prog_rd),
        .prog_wr   (prog_wr),
        .addr_l    (addr_l),
        .rd_l      (rd_l),
        .wr_l      (wr_l),
        .match     (match),
        .noreq     (noreq)
    );

    sdram_cmd_sched #(
        .LATCH      (LATCH),
        .COL_W      (COL_W),
        .REF_PERIOD (REF_PERIOD)
    ) u_sdram_cmd_sched (
        .clk       (clk),
        .rst       (rst),
        .addr_l    (addr_l),
        .rd_l      (rd_l),
        .wr_l      (wr_l),
        .match     (match),
        .noreq     (noreq),
        .open      (open),
        .prog_en   (prog_en),
        .prog_rd   (prog_rd),
        .prog_wr   (prog_wr),
        .prog_addr (prog_addr),
        .cmd       (cmd),
        .ack       (ack),
        .prog_ack  (prog_ack)
    );

endmodule

`default_nettype wire

/* logic/sdram_cmd_sched.sv */
`default_nettype none

// Command scheduler.
// One bank request is picked round-robin in IDLE and turned into the next
// command it needs: PRE when another row is open, ACT when the bank is
// closed, and RD or WR (with its ack) once the row matches. Every command
// is followed by a NOP cycle in GAP. A programming access takes over the
// bus while prog_en is high, and an idle front end gets PREA then REF when
// the refresh timer has run out.
module sdram_cmd_sched #(
    parameter int   LATCH      = 0,
    parameter int   COL_W      = 9,
    parameter int   REF_PERIOD = 64,
    localparam int  AW         = sdram_geom_pkg::ROW_W + COL_W
) (
    input  wire logic                                      clk,
    input  wire logic                                      rst,
    input  wire logic [sdram_geom_pkg::BANK_N-1:0][AW-1:0] addr_l,
    input  wire sdram_geom_pkg::bank_mask_t                rd_l,
    input  wire sdram_geom_pkg::bank_mask_t                wr_l,
    input  wire sdram_geom_pkg::bank_mask_t                match,
    input  wire logic                                      noreq,
    input  wire sdram_geom_pkg::bank_mask_t                open,
    input  wire logic                                      prog_en,
    input  wire logic                                      prog_rd,
    input  wire logic                                      prog_wr,
    input  wire logic [AW+1:0]                             prog_addr,
    output sdram_cmd_pkg::sdram_cmd_t                      cmd,
    output sdram_geom_pkg::bank_mask_t                     ack,
    output logic                                           prog_ack
);

    localparam int RW = $clog2(REF_PERIOD + 1);

    typedef enum logic [1:0] {
        IDLE,
        GAP,
        REF_WAIT
    } state_e;

    state_e state;
    state_e state_nx;

    // Round-robin pointer, the first bank looked at in IDLE.
    sdram_geom_pkg::bank_t rr;
    sdram_geom_pkg::bank_t sel;
    sdram_geom_pkg::bank_t idx;
    logic                  found;

    // Per-bank mask counters after an ack, covering the latch's stale copy.
    logic [sdram_geom_pkg::BANK_N-1:0][1:0] mask_cnt;
    sdram_geom_pkg::bank_mask_t             pend;

    // Refresh timer and the flag that carries PREA over to REF.
    logic [RW-1:0] ref_cnt;
    logic          ref_go;

    // Row last activated in each bank by this scheduler.
    // Only the programming path needs it; bank ports get match from the latch.
    sdram_geom_pkg::row_t [sdram_geom_pkg::BANK_N-1:0] act_row;

    // Fields of the programming address. The bank is on top of the row.
    sdram_geom_pkg::bank_t prog_bank;
    sdram_geom_pkg::row_t  prog_row;
    logic                  prog_hit;

    assign prog_bank = prog_addr[AW+1 -: 2];
    assign prog_row  = prog_addr[AW-1 -: sdram_geom_pkg::ROW_W];
    assign prog_hit  = open[prog_bank] && (act_row[prog_bank] == prog_row);

    // A bank competes when it requests and is not masked.
    always_comb begin
        for (int i = 0; i < sdram_geom_pkg::BANK_N; i++) begin
            pend[i] = (rd_l[i] | wr_l[i]) && (mask_cnt[i] == 2'd0);
        end
    end

    // Search from rr upward with wrap-around; the first pending bank wins.
    always_comb begin
        sel   = rr;
        found = 1'b0;
        idx   = rr;
        for (int k = 0; k < sdram_geom_pkg::BANK_N; k++) begin
            idx = rr + sdram_geom_pkg::bank_t'(k);
            if (!found && pend[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    // Command decode. The bus is combinational so that the ack lines up
    // with its RD or WR in the same cycle.
    always_comb begin
        cmd      = '0;
        ack      = '0;
        prog_ack = 1'b0;
        state_nx = state;
        case (state)
            GAP: begin
                state_nx = ref_go ? REF_WAIT : IDLE;
            end
            REF_WAIT: begin
                cmd.op   = sdram_cmd_pkg::REF;
                state_nx = GAP;
            end
            default: begin
                if (prog_en) begin
                    // Bank ports wait; only the programming port is served.
                    if (prog_rd | prog_wr) begin
                        cmd.bank = prog_bank;
                        cmd.row  = prog_row;
                        cmd.col  = sdram_geom_pkg::col_t'(prog_addr[COL_W-1:0]);
                        if (prog_hit) begin
                            cmd.op   = prog_rd ? sdram_cmd_pkg::RD : sdram_cmd_pkg::WR;
                            prog_ack = 1'b1;
                        end else if (open[prog_bank]) begin
                            cmd.op = sdram_cmd_pkg::PRE;
                        end else begin
                            cmd.op = sdram_cmd_pkg::ACT;
                        end
                        state_nx = GAP;
                    end
                end else if (ref_cnt == '0 && noreq) begin
                    cmd.op   = sdram_cmd_pkg::PREA;
                    state_nx = GAP;
                end else if (found) begin
                    cmd.bank = sel;
                    cmd.row  = addr_l[sel][AW-1 -: sdram_geom_pkg::ROW_W];
                    cmd.col  = sdram_geom_pkg::col_t'(addr_l[sel][COL_W-1:0]);
                    if (match[sel]) begin
                        cmd.op   = rd_l[sel] ? sdram_cmd_pkg::RD : sdram_cmd_pkg::WR;
                        ack[sel] = 1'b1;
                    end else if (open[sel]) begin
                        cmd.op = sdram_cmd_pkg::PRE;
                    end else begin
                        cmd.op = sdram_cmd_pkg::ACT;
                    end
                    state_nx = GAP;
                end
            end
        endcase
    end

    // Reset lands in GAP so the first cycle out of reset is a NOP.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= GAP;
            rr       <= '0;
            mask_cnt <= '0;
            ref_cnt  <= RW'(REF_PERIOD);
            ref_go   <= 1'b0;
        end else begin
            state <= state_nx;
            // Move past the bank just served so the others get their turn.
            if (|ack) begin
                rr <= sel + sdram_geom_pkg::bank_t'(1);
            end
            for (int i = 0; i < sdram_geom_pkg::BANK_N; i++) begin
                if (ack[i]) begin
                    mask_cnt[i] <= 2'(1 + LATCH);
                end else if (mask_cnt[i] != 2'd0) begin
                    mask_cnt[i] <= mask_cnt[i] - 2'd1;
                end
            end
            // The timer waits at zero until the refresh actually goes out.
            if (cmd.op == sdram_cmd_pkg::REF) begin
                ref_cnt <= RW'(REF_PERIOD);
                ref_go  <= 1'b0;
            end else begin
                if (ref_cnt != '0) begin
                    ref_cnt <= ref_cnt - 1'b1;
                end
                if (cmd.op == sdram_cmd_pkg::PREA) begin
                    ref_go <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.op == sdram_cmd_pkg::ACT) begin
            act_row[cmd.bank] <= cmd.row;
        end
    end

endmodule

`default_nettype wire

/* logic/sdram_req_latch.sv */
`default_nettype none

// Request latch between the bank ports and the scheduler.
// It compares each request's row with the open row of its bank and flags
// the case where nothing at all is requested. With LATCH set to 1 every
// output is registered, which adds one cycle but shortens the path into
// the scheduler; with LATCH at 0 the outputs follow the inputs directly.
module sdram_req_latch #(
    parameter int   LATCH = 0,
    parameter int   COL_W = 9,
    localparam int  AW    = sdram_geom_pkg::ROW_W + COL_W
) (
    input  wire logic                                          clk,
    input  wire logic                                          rst,
    input  wire logic [sdram_geom_pkg::BANK_N-1:0][AW-1:0]     bank_addr,
    input  wire sdram_geom_pkg::row_t [sdram_geom_pkg::BANK_N-1:0] open_row,
    input  wire sdram_geom_pkg::bank_mask_t                    open,
    input  wire sdram_geom_pkg::bank_mask_t                    rd,
    input  wire sdram_geom_pkg::bank_mask_t                    wr,
    input  wire logic                                          prog_en,
    input  wire logic                                          prog_rd,
    input  wire logic                                          prog_wr,
    output logic [sdram_geom_pkg::BANK_N-1:0][AW-1:0]          addr_l,
    output sdram_geom_pkg::bank_mask_t                         rd_l,
    output sdram_geom_pkg::bank_mask_t                         wr_l,
    output sdram_geom_pkg::bank_mask_t                         match,
    output logic                                               noreq
);

    // Combinational row match for every bank.
    sdram_geom_pkg::bank_mask_t match_c;
    // Combinational no-request flag.
    logic                       noreq_c;
    // An enabled programming access counts as a request too.
    logic                       prog_rq;

    assign prog_rq = prog_en & (prog_rd | prog_wr);
    assign noreq_c = ~|{rd, wr, prog_rq};

    // The row sits in the upper bits of each bank address.
    // A closed bank never matches, whatever its stale row register holds.
    always_comb begin
        for (int i = 0; i < sdram_geom_pkg::BANK_N; i++) begin
            match_c[i] = open[i] &&
                         (bank_addr[i][AW-1 -: sdram_geom_pkg::ROW_W] == open_row[i]);
        end
    end

    if (LATCH == 1) begin : g_reg
        // Flags are control state.
        // noreq comes out of reset high so that nothing is scheduled yet.
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                rd_l  <= '0;
                wr_l  <= '0;
                match <= '0;
                noreq <= 1'b1;
            end else begin
                rd_l  <= rd;
                wr_l  <= wr;
                match <= match_c;
                noreq <= noreq_c;
            end
        end

        // Addresses are payload and are only read along with a flag.
        always_ff @(posedge clk) begin
            addr_l <= bank_addr;
        end
    end else begin : g_comb
        // Pass-through build, zero cycles from port to scheduler.
        assign addr_l = bank_addr;
        assign rd_l   = rd;
        assign wr_l   = wr;
        assign match  = match_c;
        assign noreq  = noreq_c;
    end

endmodule

`default_nettype wire

/* logic/sdram_bank_track.sv */
`default_nettype none

// Open-row tracker for one bank.
// It follows the command bus and remembers whether its bank has an active
// row, and which one. The scheduler and the request latch read the result.
module sdram_bank_track (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire sdram_geom_pkg::bank_t      bank_id,
    input  wire sdram_cmd_pkg::sdram_cmd_t  cmd,
    output sdram_geom_pkg::row_t            open_row,
    output logic                            open
);

    // True when the command on the bus addresses this bank.
    logic hit;

    assign hit = (cmd.bank == bank_id);

    // The open flag is control state and is cleared on reset, so the bank
    // starts out closed.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            open <= 1'b0;
        end else begin
            case (cmd.op)
                // An ACTIVATE to this bank opens it.
                sdram_cmd_pkg::ACT: begin
                    if (hit) begin
                        open <= 1'b1;
                    end
                end
                // A single-bank PRECHARGE closes only the addressed bank.
                sdram_cmd_pkg::PRE: begin
                    if (hit) begin
                        open <= 1'b0;
                    end
                end
                // PRECHARGE-ALL closes every bank.
                // REFRESH is only issued with all banks closed, but the
                // tracker clears anyway so it can never disagree.
                sdram_cmd_pkg::PREA,
                sdram_cmd_pkg::REF: begin
                    open <= 1'b0;
                end
                default: begin
                    open <= open;
                end
            endcase
        end
    end

    // The row number is only meaningful while open is set.
    // It is loaded by every ACTIVATE to this bank.
    always_ff @(posedge clk) begin
        if (cmd.op == sdram_cmd_pkg::ACT && hit) begin
            open_row <= cmd.row;
        end
    end

endmodule

`default_nettype wire

/* logic/sdram_cmd_pkg.sv */
`default_nettype none

// The command bus between the scheduler and the bank trackers.
package sdram_cmd_pkg;

    // SDRAM operations.
    // NOP must stay at code zero, since a cleared command is an idle bus.
    typedef enum logic [2:0] {
        NOP  = 3'd0,
        ACT  = 3'd1,
        PRE  = 3'd2,
        PREA = 3'd3,
        RD   = 3'd4,
        WR   = 3'd5,
        REF  = 3'd6
    } sdram_op_e;

    // One command as it appears on the bus for a single cycle.
    // bank and row matter to ACT and PRE; bank and col matter to RD and WR.
    // PREA and REF ignore every field but op.
    typedef struct packed {
        sdram_op_e            op;
        sdram_geom_pkg::bank_t bank;
        sdram_geom_pkg::row_t  row;
        sdram_geom_pkg::col_t  col;
    } sdram_cmd_t;

endpackage

`default_nettype wire

/* logic/sdram_geom_pkg.sv */
`default_nettype none

// Address geometry of the SDRAM seen by the request front end.
// The column width of a given build is a module parameter, so only its
// upper bound lives here.
package sdram_geom_pkg;

    // Width of a row number.
    localparam int ROW_W = 12;

    // Number of banks, and so the number of request ports.
    localparam int BANK_N = 4;

    // Upper bound for the column width.
    localparam int COL_W_MAX = 10;

    // A row number, as held by the open-row trackers.
    typedef logic [ROW_W-1:0] row_t;

    // A bank index.
    typedef logic [$clog2(BANK_N)-1:0] bank_t;

    // One flag per bank (requests, acknowledges, open flags).
    typedef logic [BANK_N-1:0] bank_mask_t;

    // A column number.
    // Narrower columns sit in the low bits with the rest at zero.
    typedef logic [COL_W_MAX-1:0] col_t;

endpackage

`default_nettype wire
